// File: hdl/csr_file.sv
/* machine CSRs of the slice plus the perf counter bank, one access per cycle
   write/set/clear are applied against the current read value */
`include "dbg_csr_cfg.svh"

module csr_file
  import csr_pkg::*;
  import dbg_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic [3:0]         core_id_i,
  input  logic [5:0]         cluster_id_i,
  input  logic               access_i,
  input  csr_op_e            op_i,
  input  logic [`CSR_AW-1:0] addr_i,
  input  csr_word_t          wdata_i,
  input  logic               load_ev_i,
  input  logic               store_ev_i,
  input  halt_state_e        state_i,
  output csr_word_t          rdata_o
);

  csr_word_t              mscratch_q;
  csr_word_t              mepc_q;
  logic [`N_PERF_CNT-1:0] pcer_q;
  csr_word_t              cnt_cyc;
  csr_word_t              cnt_ld;
  csr_word_t              cnt_st;
  csr_word_t              wdata_eff;
  logic                   csr_we;
  logic                   cnt_wr;
  cnt_sel_e               cnt_sel;

  //////////////////////////////////////////////////
  // read mux, purely combinational
  always_comb
  begin
    case (addr_i)
      `CSR_MSCRATCH: rdata_o = mscratch_q;
      `CSR_MEPC:     rdata_o = mepc_q;
      `CSR_MHARTID:  rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      `CSR_PCER:     rdata_o = {{(`XLEN-`N_PERF_CNT){1'b0}}, pcer_q};
      `CSR_PCCR_CYC: rdata_o = cnt_cyc;
      `CSR_PCCR_LD:  rdata_o = cnt_ld;
      `CSR_PCCR_ST:  rdata_o = cnt_st;
      default:       rdata_o = '0;  // unmapped
    endcase
  end

  // read-modify-write value
  always_comb
  begin
    csr_we = access_i;
    case (op_i)
      CSR_OP_WRITE: wdata_eff = wdata_i;
      CSR_OP_SET:   wdata_eff = rdata_o | wdata_i;
      CSR_OP_CLEAR: wdata_eff = rdata_o & ~wdata_i;
      default:
      begin
        wdata_eff = rdata_o;  // plain read
        csr_we    = 1'b0;
      end
    endcase
  end

  // counter addresses go to the counter bank
  always_comb
  begin
    cnt_wr  = csr_we;
    cnt_sel = CNT_CYC;
    case (addr_i)
      `CSR_PCCR_CYC: cnt_sel = CNT_CYC;
      `CSR_PCCR_LD:  cnt_sel = CNT_LD;
      `CSR_PCCR_ST:  cnt_sel = CNT_ST;
      default:       cnt_wr  = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mscratch_q <= `CSR_RST_VAL;
      mepc_q     <= `CSR_RST_VAL;
      pcer_q     <= `PCER_RST_VAL;
    end
    else if (csr_we)
    begin
      case (addr_i)
        `CSR_MSCRATCH: mscratch_q <= wdata_eff;
        `CSR_MEPC:     mepc_q     <= wdata_eff;
        `CSR_PCER:     pcer_q     <= wdata_eff[`N_PERF_CNT-1:0];
        default: ;  // mhartid read-only, counters handled below
      endcase
    end
  end

  perf_counters perf_counters_inst (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .state_i    ( state_i    ),
    .enable_i   ( pcer_q     ),
    .load_ev_i  ( load_ev_i  ),
    .store_ev_i ( store_ev_i ),
    .wr_i       ( cnt_wr     ),
    .wr_sel_i   ( cnt_sel    ),
    .wr_data_i  ( wdata_eff  ),
    .cnt_cyc_o  ( cnt_cyc    ),
    .cnt_ld_o   ( cnt_ld     ),
    .cnt_st_o   ( cnt_st     )
  );

endmodule

// File: hdl/csr_pkg.sv
/* CSR side types: data word, operation codes, core request and counter select
   imported by the CSR file, the counters, the debug port and the top level */
`include "dbg_csr_cfg.svh"

package csr_pkg;

  typedef logic [`XLEN-1:0] csr_word_t;

  // csr operation, same coding as the core decoder
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // what the core presents to the CSR block each cycle
  typedef struct packed {
    logic               access;  // request valid
    csr_op_e            op;
    logic [`CSR_AW-1:0] addr;
    csr_word_t          wdata;
  } csr_req_t;

  // perf counter select, index into the counter array
  typedef enum logic [1:0] {
    CNT_CYC = 2'd0,
    CNT_LD  = 2'd1,
    CNT_ST  = 2'd2
  } cnt_sel_e;

endpackage

// File: hdl/dbg_bus_port.sv
/* debug bus slave, always grants, answers with rvalid one cycle later
   decodes CSR and control regions and wins the CSR port over the core */
`include "dbg_csr_cfg.svh"

module dbg_bus_port
  import csr_pkg::*;
  import dbg_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               debug_req_i,
  input  dbg_req_t           debug_i,
  input  csr_req_t           csr_req_i,      // core side request
  input  csr_word_t          csr_rdata_i,
  input  halt_state_e        state_i,
  input  logic               debug_halt_i,
  input  logic               debug_resume_i,
  output logic               debug_gnt_o,
  output logic               debug_rvalid_o,
  output csr_word_t          debug_rdata_o,
  output logic               access_o,       // to csr file
  output csr_op_e            op_o,
  output logic [`CSR_AW-1:0] addr_o,
  output csr_word_t          wdata_o,
  output logic               halt_req_o,     // to halt fsm
  output logic               resume_req_o
);

  logic      dbg_csr_hit;
  logic      dbg_ctrl_hit;
  csr_word_t ctrl_rdata;
  csr_word_t rdata_d;
  logic      rvalid_q;
  csr_word_t rdata_q;

  assign debug_gnt_o = debug_req_i;  // no back-pressure

  //////////////////////////////////////////////////
  // address decode through the union views
  assign dbg_csr_hit  = debug_req_i && (debug_i.addr.csr.region == `DBG_REGION_CSR);
  assign dbg_ctrl_hit = debug_req_i
                        && (debug_i.addr.ctrl.region == `DBG_REGION_CTRL)
                        && (debug_i.addr.ctrl.unused == '0)
                        && (debug_i.addr.ctrl.idx == `DBG_CTRL_IDX)
                        && (debug_i.addr.ctrl.offs == '0);

  // csr port mux, debug wins a collision
  assign access_o = dbg_csr_hit | csr_req_i.access;
  assign op_o     = dbg_csr_hit ? (debug_i.we ? CSR_OP_WRITE : CSR_OP_NONE)
                                : csr_req_i.op;
  assign addr_o   = dbg_csr_hit ? debug_i.addr.csr.csr_addr : csr_req_i.addr;
  assign wdata_o  = dbg_csr_hit ? debug_i.wdata : csr_req_i.wdata;

  // ctrl write bit 0, 1 halts and 0 resumes
  assign halt_req_o   = debug_halt_i | (dbg_ctrl_hit & debug_i.we & debug_i.wdata[0]);
  assign resume_req_o = debug_resume_i | (dbg_ctrl_hit & debug_i.we & ~debug_i.wdata[0]);

  // control word read view
  always_comb
  begin
    ctrl_rdata     = '0;
    ctrl_rdata[16] = (state_i == HALTED);
    ctrl_rdata[0]  = (state_i != RUNNING);  // halting or halted
  end

  assign rdata_d = dbg_csr_hit  ? csr_rdata_i :
                   dbg_ctrl_hit ? ctrl_rdata  : '0;

  //////////////////////////////////////////////////
  // response stage
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= debug_req_i;  // one pulse per grant
  end

  always_ff @(posedge clk_i)
  begin
    if (debug_req_i)
      rdata_q <= rdata_d;  // sampled in the grant cycle
  end

  assign debug_rvalid_o = rvalid_q;
  assign debug_rdata_o  = rdata_q;

  a_rvalid_after_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    debug_rvalid_o |-> $past(debug_gnt_o)
  );

endmodule

// File: hdl/dbg_csr_top.sv
/* debug and CSR slice of the core, the pipeline reduced to a busy level,
   a CSR request and the data bus handshake */
`include "dbg_csr_cfg.svh"

module dbg_csr_top
  import csr_pkg::*;
  import dbg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [3:0]  core_id_i,
  input  logic [5:0]  cluster_id_i,
  input  logic        core_busy_i,
  input  csr_req_t    csr_req_i,
  output csr_word_t   csr_rdata_o,
  input  logic        data_req_i,
  input  logic        data_gnt_i,
  input  logic        data_we_i,
  input  logic        debug_req_i,
  input  dbg_req_t    debug_i,
  output logic        debug_gnt_o,
  output logic        debug_rvalid_o,
  output csr_word_t   debug_rdata_o,
  output logic        debug_halted_o,
  input  logic        debug_halt_i,
  input  logic        debug_resume_i
);

  halt_state_e        state;
  logic               halt_req;
  logic               resume_req;
  logic               csr_access;
  csr_op_e            csr_op;
  logic [`CSR_AW-1:0] csr_addr;
  csr_word_t          csr_wdata;
  logic               load_ev;
  logic               store_ev;

  // events seen on the data handshake
  assign load_ev  = data_req_i & data_gnt_i & ~data_we_i;
  assign store_ev = data_req_i & data_gnt_i & data_we_i;

  dbg_halt_fsm dbg_halt_fsm_inst (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .halt_req_i     ( halt_req       ),
    .resume_req_i   ( resume_req     ),
    .core_busy_i    ( core_busy_i    ),
    .state_o        ( state          ),
    .debug_halted_o ( debug_halted_o )
  );

  csr_file csr_file_inst (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .core_id_i    ( core_id_i    ),
    .cluster_id_i ( cluster_id_i ),
    .access_i     ( csr_access   ),
    .op_i         ( csr_op       ),
    .addr_i       ( csr_addr     ),
    .wdata_i      ( csr_wdata    ),
    .load_ev_i    ( load_ev      ),
    .store_ev_i   ( store_ev     ),
    .state_i      ( state        ),
    .rdata_o      ( csr_rdata_o  )
  );

  dbg_bus_port dbg_bus_port_inst (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .debug_req_i    ( debug_req_i    ),
    .debug_i        ( debug_i        ),
    .csr_req_i      ( csr_req_i      ),
    .csr_rdata_i    ( csr_rdata_o    ),
    .state_i        ( state          ),
    .debug_halt_i   ( debug_halt_i   ),
    .debug_resume_i ( debug_resume_i ),
    .debug_gnt_o    ( debug_gnt_o    ),
    .debug_rvalid_o ( debug_rvalid_o ),
    .debug_rdata_o  ( debug_rdata_o  ),
    .access_o       ( csr_access     ),
    .op_o           ( csr_op         ),
    .addr_o         ( csr_addr       ),
    .wdata_o        ( csr_wdata      ),
    .halt_req_o     ( halt_req       ),
    .resume_req_o   ( resume_req     )
  );

endmodule

// File: hdl/dbg_halt_fsm.sv
/* halt/resume control, a halt request waits for the core to drain
   before halted is reported to the debug host */
module dbg_halt_fsm
  import dbg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        halt_req_i,    // pin strobe or ctrl write
  input  logic        resume_req_i,  // pin strobe or ctrl write
  input  logic        core_busy_i,   // core still has work in flight
  output halt_state_e state_o,
  output logic        debug_halted_o
);

  halt_state_e state_q;
  halt_state_e state_d;

  // next state
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      RUNNING:
      begin
        if (halt_req_i)
          state_d = HALTING;
      end
      HALTING:
      begin
        if (!core_busy_i)
          state_d = HALTED;  // first quiet cycle
      end
      HALTED:
      begin
        if (resume_req_i)
          state_d = RUNNING;
      end
      default: state_d = RUNNING;  // unused code, recover
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      state_q <= RUNNING;
    else
      state_q <= state_d;
  end

  assign state_o        = state_q;
  assign debug_halted_o = (state_q == HALTED);  // decoded from the state

  // halted only rises after a quiet cycle in HALTING
  a_halted_after_drain: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(debug_halted_o) |-> $past((state_q == HALTING) && !core_busy_i)
  );

endmodule

// File: hdl/dbg_pkg.sv
/* debug side types: address decode union, debug request and halt states
   imported wherever the debug port or the halt state is seen */
`include "dbg_csr_cfg.svh"

package dbg_pkg;

  //////////////////////////////////////////////////
  // two views of the same 15 bit debug address

  // region CSR, low bits are the csr address
  typedef struct packed {
    logic [`DBG_AW-`CSR_AW-1:0] region;
    logic [`CSR_AW-1:0]         csr_addr;
  } dbg_csr_view_t;

  // region CTRL, word index plus byte offset
  typedef struct packed {
    logic [`DBG_AW-`CSR_AW-1:0] region;
    logic [6:0]                 unused;  // must be zero
    logic [2:0]                 idx;     // control register index
    logic [1:0]                 offs;    // byte offset, word access only
  } dbg_ctrl_view_t;

  typedef union packed {
    dbg_csr_view_t  csr;
    dbg_ctrl_view_t ctrl;
  } dbg_addr_u;

  // one debug bus beat
  typedef struct packed {
    dbg_addr_u        addr;
    logic             we;
    logic [`XLEN-1:0] wdata;
  } dbg_req_t;

  // halt machine states
  typedef enum logic [1:0] {
    RUNNING = 2'd0,
    HALTING = 2'd1,  // waiting for the core to go quiet
    HALTED  = 2'd2
  } halt_state_e;

endpackage

// File: hdl/perf_counters.sv
/* cycle, load and store event counters behind the PCCR addresses
   counting is frozen while the core is halted, csr writes load a value */
`include "dbg_csr_cfg.svh"

module perf_counters
  import csr_pkg::*;
  import dbg_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  halt_state_e            state_i,
  input  logic [`N_PERF_CNT-1:0] enable_i,   // PCER bits
  input  logic                   load_ev_i,  // data handshake, read
  input  logic                   store_ev_i, // data handshake, write
  input  logic                   wr_i,
  input  cnt_sel_e               wr_sel_i,
  input  csr_word_t              wr_data_i,
  output csr_word_t              cnt_cyc_o,
  output csr_word_t              cnt_ld_o,
  output csr_word_t              cnt_st_o
);

  logic [`N_PERF_CNT-1:0] event_vec;
  logic                   count_ok;
  csr_word_t              cnt_q [`N_PERF_CNT];

  // bit order follows cnt_sel_e and PCER
  assign event_vec = {store_ev_i, load_ev_i, 1'b1};  // cycle event every clock
  assign count_ok  = (state_i != HALTED);             // halting still counts

  for (genvar i = 0; i < `N_PERF_CNT; i++)
  begin : g_cnt
    logic wr_hit;

    assign wr_hit = wr_i && (wr_sel_i == cnt_sel_e'(i));

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        cnt_q[i] <= `CSR_RST_VAL;
      else if (wr_hit)
        cnt_q[i] <= wr_data_i;  // load beats increment
      else if (count_ok && enable_i[i] && event_vec[i])
        cnt_q[i] <= cnt_q[i] + 1'b1;
    end

    // halted freezes every counter unless the debugger loads it
    a_frozen_when_halted: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (state_i == HALTED) && !wr_hit |=> $stable(cnt_q[i])
    );
  end

  assign cnt_cyc_o = cnt_q[CNT_CYC];
  assign cnt_ld_o  = cnt_q[CNT_LD];
  assign cnt_st_o  = cnt_q[CNT_ST];

endmodule

// File: include/dbg_csr_cfg.svh
/* widths, CSR map and debug address map of the debug/CSR slice
   included by both packages and by every module that decodes an address */
`ifndef DBG_CSR_CFG_SVH
`define DBG_CSR_CFG_SVH

//////////////////////////////////////////////////
// widths
`define XLEN         32
`define CSR_AW       12
`define DBG_AW       15     // region + csr address
`define N_PERF_CNT   3      // cycles, loads, stores

//////////////////////////////////////////////////
// CSR addresses
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MHARTID  12'hF14 // cluster/core id, read-only
`define CSR_PCER     12'h7A0 // bit 0 cyc, bit 1 ld, bit 2 st
`define CSR_PCCR_CYC 12'h780
`define CSR_PCCR_LD  12'h781
`define CSR_PCCR_ST  12'h782

// reset values
`define CSR_RST_VAL  32'h0000_0000
`define PCER_RST_VAL 3'b000  // all counters off

//////////////////////////////////////////////////
// debug address map, top 3 bits pick the region
`define DBG_REGION_CSR  3'b100
`define DBG_REGION_CTRL 3'b000
`define DBG_CTRL_IDX    3'd0 // halt/resume control word

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the debug/CSR slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dbg_csr_top -f sources.f -o tb_dbg_csr_top_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_dbg_csr_top_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: sources.f
+incdir+include
hdl/csr_pkg.sv
hdl/dbg_pkg.sv
hdl/dbg_halt_fsm.sv
hdl/perf_counters.sv
hdl/csr_file.sv
hdl/dbg_bus_port.sv
hdl/dbg_csr_top.sv
testbench/tb_dbg_csr_top.sv

// File: testbench/tb_dbg_csr_top.sv
/* directed testbench for the debug/CSR slice, drives the debug bus, core CSR port
   and data handshake, checks against a model built from the CSR and halt rules */
`include "dbg_csr_cfg.svh"

module tb_dbg_csr_top
  import csr_pkg::*;
  import dbg_pkg::*;
;

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 8;
  localparam int          N_TESTS      = 5;
  localparam int          WATCHDOG_CYC = RESET_CYCLES + 200 * N_TESTS;
  localparam logic [3:0]  CORE_ID      = 4'h5;
  localparam logic [5:0]  CLUSTER_ID   = 6'h2a;
  localparam logic [31:0] SEED         = 32'h9af5_957a;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        core_busy_i;
  csr_req_t    csr_req_i;
  csr_word_t   csr_rdata_o;
  logic        data_req_i;
  logic        data_gnt_i;
  logic        data_we_i;
  logic        debug_req_i;
  dbg_req_t    debug_i;
  logic        debug_gnt_o;
  logic        debug_rvalid_o;
  csr_word_t   debug_rdata_o;
  logic        debug_halted_o;
  logic        debug_halt_i;
  logic        debug_resume_i;

  int err_count    = 0;
  int check_count  = 0;
  int tests_passed = 0;

  dbg_csr_top dbg_csr_top_inst (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .core_id_i      ( CORE_ID        ),
    .cluster_id_i   ( CLUSTER_ID     ),
    .core_busy_i    ( core_busy_i    ),
    .csr_req_i      ( csr_req_i      ),
    .csr_rdata_o    ( csr_rdata_o    ),
    .data_req_i     ( data_req_i     ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_we_i      ( data_we_i      ),
    .debug_req_i    ( debug_req_i    ),
    .debug_i        ( debug_i        ),
    .debug_gnt_o    ( debug_gnt_o    ),
    .debug_rvalid_o ( debug_rvalid_o ),
    .debug_rdata_o  ( debug_rdata_o  ),
    .debug_halted_o ( debug_halted_o ),
    .debug_halt_i   ( debug_halt_i   ),
    .debug_resume_i ( debug_resume_i )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // compare tasks and bus helpers

  task automatic check_word(input string name, input csr_word_t exp, input csr_word_t act);
    check_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("[FAIL] t=%0t %s: expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_state(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("[FAIL] t=%0t %s: expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;  // inputs move just after the edge
  endtask

  function automatic dbg_addr_u csr_debug_addr(input logic [`CSR_AW-1:0] addr);
    dbg_addr_u a;
    a.csr.region   = `DBG_REGION_CSR;
    a.csr.csr_addr = addr;
    return a;
  endfunction

  function automatic dbg_addr_u ctrl_debug_addr(input logic [2:0] idx);
    dbg_addr_u a;
    a               = '0;
    a.ctrl.region   = `DBG_REGION_CTRL;
    a.ctrl.idx      = idx;
    return a;
  endfunction

  // one debug beat, returns just after the grant edge
  task automatic issue_beat(input logic we, input dbg_addr_u addr, input csr_word_t wdata);
    debug_req_i   = 1'b1;
    debug_i.addr  = addr;
    debug_i.we    = we;
    debug_i.wdata = wdata;
    @(posedge clk_i);
    if (!debug_gnt_o)
    begin
      err_count++;
      $display("t=%0t debug request was not granted", $time);
    end
    #1;
    debug_req_i = 1'b0;
    debug_i     = '0;
  endtask

  task automatic wait_rvalid(output csr_word_t data);
    int n;
    n = 0;
    while (!debug_rvalid_o && n < 8)
    begin
      next_cycle();
      n++;
    end
    if (!debug_rvalid_o)
    begin
      err_count++;
      $display("t=%0t no debug read-valid pulse after the grant", $time);
    end
    data = debug_rdata_o;
  endtask

  task automatic dbg_read(input dbg_addr_u addr, output csr_word_t data);
    issue_beat(1'b0, addr, '0);
    wait_rvalid(data);
  endtask

  task automatic dbg_write(input dbg_addr_u addr, input csr_word_t wdata);
    csr_word_t unused_rdata;
    issue_beat(1'b1, addr, wdata);
    wait_rvalid(unused_rdata);
  endtask

  task automatic core_csr(input csr_op_e op, input logic [`CSR_AW-1:0] addr,
                          input csr_word_t wdata);
    csr_req_i.access = 1'b1;
    csr_req_i.op     = op;
    csr_req_i.addr   = addr;
    csr_req_i.wdata  = wdata;
    next_cycle();
    csr_req_i = '0;
  endtask

  // core side read, csr_rdata_o follows the address in the same cycle
  task automatic read_core_port(input logic [`CSR_AW-1:0] addr, input csr_word_t exp,
                                input string name);
    csr_req_i      = '0;
    csr_req_i.addr = addr;
    #2;  // mid cycle, combinational path settled
    check_word(name, exp, csr_rdata_o);
    next_cycle();
    csr_req_i = '0;
  endtask

  // random mix of load/store handshakes, returns what should have counted
  task automatic drive_handshakes(input int cycles, input logic always_gnt,
                                  output int n_ld, output int n_st);
    n_ld = 0;
    n_st = 0;
    repeat (cycles)
    begin
      data_req_i = 1'b1;
      data_gnt_i = always_gnt | $urandom_range(1, 0);
      data_we_i  = $urandom_range(1, 0);
      if (data_gnt_i && !data_we_i)
        n_ld++;
      if (data_gnt_i && data_we_i)
        n_st++;
      next_cycle();
    end
    data_req_i = 1'b0;
    data_gnt_i = 1'b0;
    data_we_i  = 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (err_count == errs_at_start)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
      $display("test %s: %0d errors", name, err_count - errs_at_start);
  endtask

  //////////////////////////////////////////////////
  // directed tests

  task automatic reset_values();
    int        errs;
    csr_word_t rd;
    errs = err_count;
    check_state("debug_halted_o", 1'b0, debug_halted_o);
    dbg_read(csr_debug_addr(`CSR_MSCRATCH), rd);
    check_word("debug_rdata_o mscratch", 32'h0, rd);
    dbg_read(csr_debug_addr(`CSR_PCER), rd);
    check_word("debug_rdata_o pcer", 32'h0, rd);
    dbg_read(csr_debug_addr(`CSR_MHARTID), rd);
    check_word("debug_rdata_o mhartid", {21'b0, CLUSTER_ID, 1'b0, CORE_ID}, rd);
    report_test("reset_values", errs);
  endtask

  task automatic csr_operations();
    int        errs;
    csr_word_t model;
    csr_word_t w;
    csr_word_t rd;
    errs  = err_count;
    model = '0;
    repeat (12)
    begin
      w = $urandom;
      case ($urandom % 3)
        0:
        begin
          dbg_write(csr_debug_addr(`CSR_MSCRATCH), w);
          model = w;
        end
        1:
        begin
          core_csr(CSR_OP_SET, `CSR_MSCRATCH, w);
          model = model | w;
        end
        default:
        begin
          core_csr(CSR_OP_CLEAR, `CSR_MSCRATCH, w);
          model = model & ~w;
        end
      endcase
      dbg_read(csr_debug_addr(`CSR_MSCRATCH), rd);
      check_word("debug_rdata_o mscratch", model, rd);
      read_core_port(`CSR_MSCRATCH, model, "csr_rdata_o mscratch");
    end
    dbg_read(csr_debug_addr(12'h123), rd);  // unmapped csr
    check_word("debug_rdata_o unmapped csr", 32'h0, rd);
    dbg_read(ctrl_debug_addr(3'd3), rd);    // unmapped ctrl word
    check_word("debug_rdata_o unmapped ctrl", 32'h0, rd);
    dbg_write(csr_debug_addr(`CSR_MHARTID), $urandom);
    dbg_read(csr_debug_addr(`CSR_MHARTID), rd);
    check_word("debug_rdata_o mhartid", {21'b0, CLUSTER_ID, 1'b0, CORE_ID}, rd);
    report_test("csr_ops", errs);
  endtask

  task automatic csr_collision();
    int        errs;
    csr_word_t dbg_val;
    csr_word_t core_val;
    csr_word_t rd;
    errs     = err_count;
    dbg_val  = $urandom;
    core_val = ~dbg_val;
    csr_req_i.access = 1'b1;  // core write in the same cycle as the debug write
    csr_req_i.op     = CSR_OP_WRITE;
    csr_req_i.addr   = `CSR_MEPC;
    csr_req_i.wdata  = core_val;
    issue_beat(1'b1, csr_debug_addr(`CSR_MEPC), dbg_val);
    csr_req_i = '0;
    wait_rvalid(rd);
    dbg_read(csr_debug_addr(`CSR_MEPC), rd);
    check_word("debug_rdata_o mepc", dbg_val, rd);
    report_test("collision", errs);
  endtask

  task automatic counter_events();
    int        errs;
    int        n_ld;
    int        n_st;
    csr_word_t v;
    csr_word_t rd;
    errs = err_count;
    dbg_write(csr_debug_addr(`CSR_PCER), 32'h6);  // loads and stores only
    dbg_write(csr_debug_addr(`CSR_PCCR_LD), 32'h0);
    dbg_write(csr_debug_addr(`CSR_PCCR_ST), 32'h0);
    drive_handshakes(16 + $urandom % 24, 1'b0, n_ld, n_st);
    dbg_read(csr_debug_addr(`CSR_PCCR_LD), rd);
    check_word("debug_rdata_o pccr_ld", csr_word_t'(n_ld), rd);
    dbg_read(csr_debug_addr(`CSR_PCCR_ST), rd);
    check_word("debug_rdata_o pccr_st", csr_word_t'(n_st), rd);
    dbg_read(csr_debug_addr(`CSR_PCCR_CYC), rd);  // never enabled
    check_word("debug_rdata_o pccr_cyc", 32'h0, rd);
    v = $urandom;
    dbg_write(csr_debug_addr(`CSR_PCCR_ST), v);
    dbg_read(csr_debug_addr(`CSR_PCCR_ST), rd);
    check_word("debug_rdata_o pccr_st load", v, rd);
    report_test("counters", errs);
  endtask

  task automatic halt_and_resume();
    int        errs;
    int        waited;
    int        n_ld;
    int        n_st;
    csr_word_t ld_before;
    csr_word_t st_before;
    csr_word_t rd;
    csr_word_t rd2;
    errs = err_count;
    dbg_write(csr_debug_addr(`CSR_PCER), 32'h7);
    core_busy_i  = 1'b1;
    debug_halt_i = 1'b1;
    next_cycle();
    debug_halt_i = 1'b0;
    repeat (20)
    begin
      check_state("debug_halted_o", 1'b0, debug_halted_o);  // still draining
      next_cycle();
    end
    dbg_read(ctrl_debug_addr(`DBG_CTRL_IDX), rd);
    check_word("debug_rdata_o ctrl halting", 32'h0000_0001, rd);
    core_busy_i = 1'b0;
    waited      = 0;
    while (!debug_halted_o && waited < 16)
    begin
      next_cycle();
      waited++;
    end
    if (!debug_halted_o)
    begin
      err_count++;
      $display("t=%0t halted did not rise after the core went quiet", $time);
    end
    dbg_read(ctrl_debug_addr(`DBG_CTRL_IDX), rd);
    check_word("debug_rdata_o ctrl halted", 32'h0001_0001, rd);

    // counters frozen while halted
    dbg_read(csr_debug_addr(`CSR_PCCR_LD), ld_before);
    dbg_read(csr_debug_addr(`CSR_PCCR_ST), st_before);
    drive_handshakes(8, 1'b1, n_ld, n_st);
    dbg_read(csr_debug_addr(`CSR_PCCR_LD), rd);
    check_word("debug_rdata_o pccr_ld halted", ld_before, rd);
    dbg_read(csr_debug_addr(`CSR_PCCR_ST), rd);
    check_word("debug_rdata_o pccr_st halted", st_before, rd);
    dbg_read(csr_debug_addr(`CSR_PCCR_CYC), rd);
    dbg_read(csr_debug_addr(`CSR_PCCR_CYC), rd2);
    check_word("debug_rdata_o pccr_cyc halted", rd, rd2);

    issue_beat(1'b1, ctrl_debug_addr(`DBG_CTRL_IDX), 32'h0);  // resume
    check_state("debug_halted_o", 1'b0, debug_halted_o);
    wait_rvalid(rd);
    dbg_read(ctrl_debug_addr(`DBG_CTRL_IDX), rd);
    check_word("debug_rdata_o ctrl running", 32'h0, rd);
    report_test("halt_resume", errs);
  endtask

  //////////////////////////////////////////////////
  // watchdog, sized from the test count
  initial
  begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("t=%0t watchdog expired, the run did not finish in time", $time);
    $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    int seed_ret;
    seed_ret       = $urandom(SEED);  // one seed for the whole run
    rst_n_i        = 1'b0;
    core_busy_i    = 1'b0;
    csr_req_i      = '0;
    data_req_i     = 1'b0;
    data_gnt_i     = 1'b0;
    data_we_i      = 1'b0;
    debug_req_i    = 1'b0;
    debug_i        = '0;
    debug_halt_i   = 1'b0;
    debug_resume_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    next_cycle();

    reset_values();
    csr_operations();
    csr_collision();
    counter_events();
    halt_and_resume();

    $display("summary: %0d of %0d tests ok, %0d checks, %0d errors",
             tests_passed, N_TESTS, check_count, err_count);
    if (err_count == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule
